//--- source/l2_cache_consts.svh
`ifndef L2_CACHE_CONSTS_SVH
`define L2_CACHE_CONSTS_SVH

// address split of the 28-bit L1 word address
`define L2_TAG_W    18
`define L2_INDEX_W  8
`define L2_OFS_W    2
`define L2_ADDR_W   28

// cache geometry
`define L2_SETS     256
`define L2_WAYS     4

// data widths
`define L2_LINE_W   128
`define L2_WORD_W   32

`endif

//--- source/l2_cache_pkg.sv
package l2_cache_pkg;

    `include "l2_cache_consts.svh"

    // one L1 word address, seen raw on the bus or split into cache fields
    typedef union packed
    {
        logic [`L2_ADDR_W-1:0] raw;
        struct packed
        {
            logic [`L2_TAG_W-1:0]   tag;
            logic [`L2_INDEX_W-1:0] index;
            logic [`L2_OFS_W-1:0]   ofs;
        } f;
    } l2_addr_u;

    // lexicographic rank of a way ordering, first way is LRU
    typedef logic [4:0] lru_code_t;

    typedef logic [1:0] way_t;

endpackage

//--- source/l2_lookup_if.sv
`timescale 1ns/1ns
`include "l2_cache_consts.svh"

interface l2_lookup_if;
    import l2_cache_pkg::*;

    logic [`L2_INDEX_W-1:0] index;
    logic [`L2_TAG_W-1:0]   tag;
    logic                   fill;       // tag write, valid set, dirty cleared
    logic                   set_dirty;
    way_t                   way;

    logic                   hit;
    way_t                   hit_way;
    way_t                   victim_way;
    logic                   victim_valid;
    logic                   victim_dirty;
    logic [`L2_TAG_W-1:0]   victim_tag;

    modport ctrl (
        output index, tag, fill, set_dirty, way,
        input  hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag
    );

    modport store (
        input  index, tag, fill, set_dirty, way,
        output hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag
    );

endinterface

//--- source/l2_lru_table.sv
`timescale 1ns/1ns
`include "l2_cache_consts.svh"

module l2_lru_table (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    touch_en,
    input  logic [`L2_INDEX_W-1:0]  touch_index,
    input  l2_cache_pkg::way_t      touch_way,
    input  logic [`L2_INDEX_W-1:0]  rd_index,
    output l2_cache_pkg::way_t      lru_way
);
    import l2_cache_pkg::*;

    lru_code_t       codes [`L2_SETS];
    logic [3:0][1:0] rd_order;
    lru_code_t       touched;

    // code -> ordering, digits 6/2/1 pick from the remaining ways
    function automatic logic [3:0][1:0] decode(input lru_code_t code);
        logic [3:0][1:0] pool;
        logic [3:0][1:0] order;
        logic [1:0]      dig [4];
        pool = {2'd3, 2'd2, 2'd1, 2'd0};
        dig[0] = 2'(code / 6);
        dig[1] = 2'((code % 6) / 2);
        dig[2] = 2'(code % 2);
        dig[3] = 2'd0;
        for (int i = 0; i < 4; i++)
        begin
            order[i] = pool[dig[i]];
            for (int j = 0; j < 3; j++)
                if (j >= dig[i])
                    pool[j] = pool[j+1];    // close the gap
        end
        return order;
    endfunction

    function automatic lru_code_t encode(input logic [3:0][1:0] order);
        lru_code_t  code;
        logic [1:0] cnt;
        code = '0;
        for (int i = 0; i < 3; i++)
        begin
            cnt = '0;
            for (int j = i + 1; j < 4; j++)
                if (order[j] < order[i])
                    cnt = cnt + 2'd1;
            code = lru_code_t'(code * (4 - i) + cnt);
        end
        return code;
    endfunction

    function automatic logic [3:0][1:0] move_to_mru(input logic [3:0][1:0] order, input way_t w);
        logic [3:0][1:0] res;
        int              k;
        res = order;
        k = 0;
        for (int i = 0; i < 4; i++)
        begin
            if (order[i] != w)
            begin
                res[k] = order[i];
                k++;
            end
        end
        res[3] = w;     // most recent at the tail
        return res;
    endfunction

    assign rd_order = decode(codes[rd_index]);
    assign lru_way  = rd_order[0];
    assign touched  = encode(move_to_mru(decode(codes[touch_index]), touch_way));

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < `L2_SETS; s++)
                codes[s] <= '0;     // ordering 0,1,2,3
        end
        else if (touch_en)
            codes[touch_index] <= touched;
    end

endmodule

//--- source/l2_tag_store.sv
`timescale 1ns/1ns
`include "l2_cache_consts.svh"

module l2_tag_store (
    input  logic                clk,
    input  logic                nrst,
    l2_lookup_if.store          lk,
    input  l2_cache_pkg::way_t  lru_way
);
    import l2_cache_pkg::*;

    logic [`L2_TAG_W-1:0]           tags [`L2_SETS*`L2_WAYS];
    logic [`L2_SETS*`L2_WAYS-1:0]   valid;
    logic [`L2_SETS*`L2_WAYS-1:0]   dirty;

    logic [`L2_WAYS-1:0]    way_valid;
    logic [`L2_WAYS-1:0]    way_dirty;
    logic [`L2_WAYS-1:0]    way_match;
    logic [`L2_TAG_W-1:0]   way_tag [`L2_WAYS];
    way_t                   victim;
    way_t                   match_way;

    // read out the whole set and compare all four ways
    always_comb
    begin
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            way_tag[w]   = tags[{lk.index, way_t'(w)}];
            way_valid[w] = valid[{lk.index, way_t'(w)}];
            way_dirty[w] = dirty[{lk.index, way_t'(w)}];
            way_match[w] = way_valid[w] && (way_tag[w] == lk.tag);
        end
    end

    always_comb
    begin
        match_way = '0;
        victim    = lru_way;    // set full, evict LRU
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (way_match[w])
                match_way = way_t'(w);
            if (!way_valid[w])
                victim = way_t'(w);     // lowest empty way wins
        end
    end

    assign lk.hit          = |way_match;
    assign lk.hit_way      = match_way;
    assign lk.victim_way   = victim;
    assign lk.victim_valid = way_valid[victim];
    assign lk.victim_dirty = way_dirty[victim];
    assign lk.victim_tag   = way_tag[victim];

    always_ff @(posedge clk)
    begin
        if (lk.fill)
            tags[{lk.index, lk.way}] <= lk.tag;
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (lk.fill)
        begin
            valid[{lk.index, lk.way}] <= 1'b1;
            dirty[{lk.index, lk.way}] <= 1'b0;     // fresh line from memory
        end
        else if (lk.set_dirty)
            dirty[{lk.index, lk.way}] <= 1'b1;
    end

endmodule

//--- source/l2_data_array.sv
`timescale 1ns/1ns
`include "l2_cache_consts.svh"

module l2_data_array (
    input  logic                    clk,
    input  logic [`L2_INDEX_W-1:0]  index,
    input  l2_cache_pkg::way_t      way,
    input  logic [`L2_OFS_W-1:0]    word_sel,
    input  logic                    wr_en,
    input  logic [`L2_WORD_W-1:0]   wr_word,
    input  logic                    refill_en,
    input  logic [`L2_LINE_W-1:0]   refill_line,
    output logic [`L2_WORD_W-1:0]   rd_word,
    output logic [`L2_LINE_W-1:0]   rd_line
);

    logic [`L2_LINE_W-1:0]      lines [`L2_SETS*`L2_WAYS];
    logic [`L2_INDEX_W+1:0]     line_sel;

    assign line_sel = {index, way};

    // refill has priority, a write hit never overlaps it
    always_ff @(posedge clk)
    begin
        if (refill_en)
            lines[line_sel] <= refill_line;
        else if (wr_en)
            lines[line_sel][word_sel*`L2_WORD_W +: `L2_WORD_W] <= wr_word;
    end

    // registered read, one cycle after address
    always_ff @(posedge clk)
    begin
        rd_word <= lines[line_sel][word_sel*`L2_WORD_W +: `L2_WORD_W];
        rd_line <= lines[line_sel];     // victim for write-back
    end

endmodule

//--- source/l2_controller.sv
`timescale 1ns/1ns
`include "l2_cache_consts.svh"

module l2_controller (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            l1_cyc,
    input  logic                            l1_stb,
    input  logic                            l1_we,
    input  l2_cache_pkg::l2_addr_u          l1_adr,
    input  logic [`L2_WORD_W-1:0]           l1_wdata,
    output logic                            l1_ack,
    output logic                            mem_cyc,
    output logic                            mem_stb,
    output logic                            mem_we,
    output logic [`L2_TAG_W+`L2_INDEX_W-1:0] mem_adr,
    input  logic                            mem_ack,
    l2_lookup_if.ctrl                       lk,
    output logic                            touch_en,
    output logic [`L2_INDEX_W-1:0]          touch_index,
    output l2_cache_pkg::way_t              touch_way,
    input  l2_cache_pkg::way_t              lru_way,
    output logic [`L2_INDEX_W-1:0]          index,
    output l2_cache_pkg::way_t              way,
    output logic [`L2_OFS_W-1:0]            word_sel,
    output logic                            wr_en,
    output logic [`L2_WORD_W-1:0]           wr_word,
    output logic                            refill_en
);
    import l2_cache_pkg::*;

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_COMPARE,
        S_WRITE_BACK,
        S_ALLOCATE
    } state_t;

    state_t state;
    logic   hit_q;      // second compare cycle, data array addressed
    way_t   way_q;
    logic   req;
    logic   need_wb;
    logic   mem_done;

    // ack cycle still shows stb, don't restart on it
    assign req      = l1_cyc && l1_stb && !l1_ack;
    assign need_wb  = lk.victim_valid && lk.victim_dirty;
    assign mem_done = mem_cyc && mem_ack;

    assign lk.index     = l1_adr.f.index;
    assign lk.tag       = l1_adr.f.tag;
    assign lk.way       = way_q;
    assign lk.fill      = refill_en;
    assign lk.set_dirty = wr_en;

    assign index    = l1_adr.f.index;
    assign way      = way_q;
    assign word_sel = l1_adr.f.ofs;
    assign wr_word  = l1_wdata;

    assign wr_en       = (state == S_COMPARE) && hit_q && l1_we;
    assign refill_en   = (state == S_ALLOCATE) && mem_done;   // mem_rdata goes straight in
    assign touch_en    = (state == S_COMPARE) && hit_q;
    assign touch_index = l1_adr.f.index;
    assign touch_way   = way_q;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state   <= S_IDLE;
            hit_q   <= 1'b0;
            way_q   <= '0;
            l1_ack  <= 1'b0;
            mem_cyc <= 1'b0;
            mem_stb <= 1'b0;
            mem_we  <= 1'b0;
        end
        else
        begin
            l1_ack <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (req)
                        state <= S_COMPARE;
                end
                S_COMPARE:
                begin
                    if (hit_q)
                    begin
                        hit_q  <= 1'b0;
                        l1_ack <= 1'b1;     // rd_word valid alongside
                        state  <= S_IDLE;
                    end
                    else if (lk.hit)
                    begin
                        hit_q <= 1'b1;
                        way_q <= lk.hit_way;
                    end
                    else
                    begin
                        way_q <= lk.victim_way;
                        state <= need_wb ? S_WRITE_BACK : S_ALLOCATE;
                    end
                end
                S_WRITE_BACK:
                begin
                    if (!mem_cyc)
                    begin
                        // rd_line settles one cycle after way_q
                        mem_cyc <= 1'b1;
                        mem_stb <= 1'b1;
                        mem_we  <= 1'b1;
                    end
                    else if (mem_ack)
                    begin
                        mem_cyc <= 1'b0;
                        mem_stb <= 1'b0;
                        mem_we  <= 1'b0;
                        state   <= S_ALLOCATE;
                    end
                end
                S_ALLOCATE:
                begin
                    if (!mem_cyc)
                    begin
                        mem_cyc <= 1'b1;
                        mem_stb <= 1'b1;
                    end
                    else if (mem_ack)
                    begin
                        mem_cyc <= 1'b0;
                        mem_stb <= 1'b0;
                        state   <= S_COMPARE;   // lookup again, hits now
                    end
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // line address for the next memory transfer
    always_ff @(posedge clk)
    begin
        if ((state == S_COMPARE) && !hit_q && !lk.hit)
            mem_adr <= need_wb ? {lk.victim_tag, l1_adr.f.index} : {l1_adr.f.tag, l1_adr.f.index};
        else if ((state == S_WRITE_BACK) && mem_done)
            mem_adr <= {l1_adr.f.tag, l1_adr.f.index};
    end

endmodule

//--- source/l2_cache_top.sv
`timescale 1ns/1ns
`include "l2_cache_consts.svh"

module l2_cache_top (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                l1_cyc,
    input  logic                                l1_stb,
    input  logic                                l1_we,
    input  logic [`L2_ADDR_W-1:0]               l1_adr,
    input  logic [`L2_WORD_W-1:0]               l1_wdata,
    output logic [`L2_WORD_W-1:0]               l1_rdata,
    output logic                                l1_ack,
    output logic                                mem_cyc,
    output logic                                mem_stb,
    output logic                                mem_we,
    output logic [`L2_TAG_W+`L2_INDEX_W-1:0]    mem_adr,
    output logic [`L2_LINE_W-1:0]               mem_wdata,
    input  logic [`L2_LINE_W-1:0]               mem_rdata,
    input  logic                                mem_ack
);
    import l2_cache_pkg::*;

    l2_addr_u                   req_adr;
    logic                       touch_en;
    logic [`L2_INDEX_W-1:0]     touch_index;
    way_t                       touch_way;
    way_t                       lru_way;
    logic [`L2_INDEX_W-1:0]     index;
    way_t                       way;
    logic [`L2_OFS_W-1:0]       word_sel;
    logic                       wr_en;
    logic [`L2_WORD_W-1:0]      wr_word;
    logic                       refill_en;

    l2_lookup_if lk ();

    assign req_adr = l1_adr;

    l2_controller i_l2_controller (
        .clk         (clk),
        .nrst        (nrst),
        .l1_cyc      (l1_cyc),
        .l1_stb      (l1_stb),
        .l1_we       (l1_we),
        .l1_adr      (req_adr),
        .l1_wdata    (l1_wdata),
        .l1_ack      (l1_ack),
        .mem_cyc     (mem_cyc),
        .mem_stb     (mem_stb),
        .mem_we      (mem_we),
        .mem_adr     (mem_adr),
        .mem_ack     (mem_ack),
        .lk          (lk.ctrl),
        .touch_en    (touch_en),
        .touch_index (touch_index),
        .touch_way   (touch_way),
        .lru_way     (lru_way),
        .index       (index),
        .way         (way),
        .word_sel    (word_sel),
        .wr_en       (wr_en),
        .wr_word     (wr_word),
        .refill_en   (refill_en)
    );

    l2_tag_store i_l2_tag_store (
        .clk     (clk),
        .nrst    (nrst),
        .lk      (lk.store),
        .lru_way (lru_way)
    );

    l2_lru_table i_l2_lru_table (
        .clk         (clk),
        .nrst        (nrst),
        .touch_en    (touch_en),
        .touch_index (touch_index),
        .touch_way   (touch_way),
        .rd_index    (req_adr.f.index),
        .lru_way     (lru_way)
    );

    // memory side moves whole lines in and out
    l2_data_array i_l2_data_array (
        .clk         (clk),
        .index       (index),
        .way         (way),
        .word_sel    (word_sel),
        .wr_en       (wr_en),
        .wr_word     (wr_word),
        .refill_en   (refill_en),
        .refill_line (mem_rdata),
        .rd_word     (l1_rdata),
        .rd_line     (mem_wdata)
    );

endmodule

//--- tb/l2_checker.sv
`timescale 1ns/1ns
`include "l2_cache_consts.svh"

module l2_checker (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                l1_cyc,
    input  logic                                l1_stb,
    input  logic                                l1_we,
    input  logic [`L2_ADDR_W-1:0]               l1_adr,
    input  logic [`L2_WORD_W-1:0]               l1_wdata,
    input  logic [`L2_WORD_W-1:0]               l1_rdata,
    input  logic                                l1_ack,
    input  logic                                mem_cyc,
    input  logic                                mem_stb,
    input  logic                                mem_we,
    input  logic [`L2_TAG_W+`L2_INDEX_W-1:0]    mem_adr,
    input  logic [`L2_LINE_W-1:0]               mem_wdata,
    input  logic [`L2_LINE_W-1:0]               mem_rdata,
    input  logic                                mem_ack,
    input  logic [`L2_WORD_W-1:0]               exp_rdata,
    input  logic                                run_done,
    output int                                  mismatches,
    output int                                  failures,
    output int                                  xfers
);
    import l2_cache_pkg::*;

    // cache model, order lists hold the LRU way first
    logic [`L2_TAG_W-1:0]   m_tag   [`L2_SETS][`L2_WAYS];
    logic                   m_valid [`L2_SETS][`L2_WAYS];
    logic                   m_dirty [`L2_SETS][`L2_WAYS];
    logic [`L2_LINE_W-1:0]  m_line  [`L2_SETS][`L2_WAYS];
    way_t                   m_order [`L2_SETS][`L2_WAYS];

    logic                   exp_we_q  [$];     // transfers still owed by this request
    logic [25:0]            exp_adr_q [$];
    int                     exp_xfers;
    bit                     busy;
    bit                     totals_done;
    int                     cycle;
    int                     start_cycle;
    l2_addr_u               req;
    logic                   req_we;
    logic [`L2_WORD_W-1:0]  req_wdata;
    logic                   req_hit;
    way_t                   req_way;

    function automatic void touch(input logic [`L2_INDEX_W-1:0] s, input way_t w);
        int k;
        k = 0;
        for (int i = 0; i < `L2_WAYS; i++)
        begin
            if (m_order[s][i] != w)
            begin
                m_order[s][k] = m_order[s][i];
                k++;
            end
        end
        m_order[s][`L2_WAYS-1] = w;     // now most recent
    endfunction

    // empty ways first, lowest number wins
    function automatic way_t pick_victim(input logic [`L2_INDEX_W-1:0] s);
        for (int w = 0; w < `L2_WAYS; w++)
            if (!m_valid[s][w])
                return way_t'(w);
        return m_order[s][0];
    endfunction

    function automatic void report_mismatch(input string msg);
        mismatches++;
        $display("mismatch at %0t: %s", $time, msg);
    endfunction

    task automatic start_request;
        req         = l1_adr;
        req_we      = l1_we;
        req_wdata   = l1_wdata;
        start_cycle = cycle;
        busy        = 1'b1;
        req_hit     = 1'b0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (m_valid[req.f.index][w] && m_tag[req.f.index][w] == req.f.tag)
            begin
                req_hit = 1'b1;
                req_way = way_t'(w);
            end
        end
        if (!req_hit)
        begin
            req_way = pick_victim(req.f.index);
            if (m_valid[req.f.index][req_way] && m_dirty[req.f.index][req_way])
            begin
                exp_we_q.push_back(1'b1);
                exp_adr_q.push_back({m_tag[req.f.index][req_way], req.f.index});
            end
            exp_we_q.push_back(1'b0);
            exp_adr_q.push_back({req.f.tag, req.f.index});
        end
        exp_xfers += exp_we_q.size();
    endtask

    task automatic check_transfer;
        logic        exp_we;
        logic [25:0] exp_adr;
        xfers++;
        if (!busy || exp_we_q.size() == 0)
        begin
            failures++;
            $display("unexpected memory transfer at %0t, line address %h", $time, mem_adr);
        end
        else
        begin
            exp_we  = exp_we_q.pop_front();
            exp_adr = exp_adr_q.pop_front();
            if (mem_we !== exp_we || mem_adr !== exp_adr)
                report_mismatch($sformatf("memory we=%b adr=%h, expected we=%b adr=%h",
                                          mem_we, mem_adr, exp_we, exp_adr));
            else if (mem_we)
            begin
                if (mem_wdata !== m_line[req.f.index][req_way])
                    report_mismatch($sformatf("write-back of line %h carries wrong data",
                                              mem_adr));
            end
            else
            begin
                m_line[req.f.index][req_way]  = mem_rdata;
                m_tag[req.f.index][req_way]   = req.f.tag;
                m_valid[req.f.index][req_way] = 1'b1;
                m_dirty[req.f.index][req_way] = 1'b0;
            end
        end
    endtask

    task automatic check_ack;
        if (!busy)
        begin
            failures++;
            $display("l1_ack at %0t without a request", $time);
        end
        else
        begin
            if (exp_we_q.size() != 0)
            begin
                failures++;
                $display("request finished at %0t with %0d memory transfers missing",
                         $time, exp_we_q.size());
                exp_we_q.delete();
                exp_adr_q.delete();
            end
            if (req_hit && (cycle - start_cycle) != 3)
                report_mismatch($sformatf("hit latency %0d cycles, expected 3",
                                          cycle - start_cycle));
            if (req_we)
            begin
                m_line[req.f.index][req_way][req.f.ofs*`L2_WORD_W +: `L2_WORD_W] = req_wdata;
                m_dirty[req.f.index][req_way] = 1'b1;
            end
            else if (l1_rdata !== exp_rdata)
                report_mismatch($sformatf("read %h returned %h, expected %h",
                                          req.raw, l1_rdata, exp_rdata));
            touch(req.f.index, req_way);
            busy = 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < `L2_SETS; s++)
            begin
                for (int w = 0; w < `L2_WAYS; w++)
                begin
                    m_valid[s][w] = 1'b0;
                    m_dirty[s][w] = 1'b0;
                    m_order[s][w] = way_t'(w);
                end
            end
            mismatches  = 0;
            failures    = 0;
            xfers       = 0;
            exp_xfers   = 0;
            busy        = 1'b0;
            totals_done = 1'b0;
            cycle       = 0;
        end
        else
        begin
            cycle++;
            if (mem_cyc && mem_stb && mem_ack)
                check_transfer();
            if (l1_ack)
                check_ack();
            else if (!busy && l1_cyc && l1_stb)
                start_request();
            if (run_done && !totals_done)
            begin
                totals_done = 1'b1;
                if (xfers != exp_xfers)
                begin
                    failures++;
                    $display("memory saw %0d transfers over the run, model expects %0d",
                             xfers, exp_xfers);
                end
            end
        end
    end

endmodule

//--- tb/tb_l2_cache.sv
`timescale 1ns/1ns
`include "l2_cache_consts.svh"

module tb_l2_cache;
    import l2_cache_pkg::*;

    localparam int N_DIRECTED      = 17;
    localparam int N_RANDOM        = 400;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 200 + 100;

    logic                               clk;
    logic                               nrst;
    logic                               l1_cyc;
    logic                               l1_stb;
    logic                               l1_we;
    logic [`L2_ADDR_W-1:0]              l1_adr;
    logic [`L2_WORD_W-1:0]              l1_wdata;
    logic [`L2_WORD_W-1:0]              l1_rdata;
    logic                               l1_ack;
    logic                               mem_cyc;
    logic                               mem_stb;
    logic                               mem_we;
    logic [`L2_TAG_W+`L2_INDEX_W-1:0]   mem_adr;
    logic [`L2_LINE_W-1:0]              mem_wdata;
    logic [`L2_LINE_W-1:0]              mem_rdata;
    logic                               mem_ack;

    logic [`L2_WORD_W-1:0]  exp_rdata;
    logic                   run_done;
    int                     mismatches;
    int                     failures;
    int                     xfers;
    int                     seed;
    int                     delay_seed;     // memory delays, own stream
    int                     mem_wait;
    logic [`L2_LINE_W-1:0]  mem_lines [int unsigned];
    logic [`L2_WORD_W-1:0]  shadow [int unsigned];     // every L1 write so far

    function automatic logic [`L2_WORD_W-1:0] pattern_word(input logic [`L2_ADDR_W-1:0] a);
        return (32'(a) * 32'h9e37_79b1) ^ {4'h5, a};
    endfunction

    function automatic logic [`L2_LINE_W-1:0] memory_line(input logic [25:0] la);
        logic [`L2_LINE_W-1:0] line;
        if (mem_lines.exists(32'(la)))
            return mem_lines[32'(la)];
        for (int i = 0; i < 4; i++)
            line[i*`L2_WORD_W +: `L2_WORD_W] = pattern_word({la, 2'(i)});
        return line;
    endfunction

    function automatic logic [`L2_WORD_W-1:0] expected_word(input logic [`L2_ADDR_W-1:0] a);
        if (shadow.exists(32'(a)))
            return shadow[32'(a)];
        return pattern_word(a);
    endfunction

    function automatic logic [`L2_ADDR_W-1:0] make_adr(input logic [`L2_TAG_W-1:0] tag,
                                                       input logic [`L2_INDEX_W-1:0] index,
                                                       input logic [`L2_OFS_W-1:0] ofs);
        l2_addr_u a;
        a.f.tag   = tag;
        a.f.index = index;
        a.f.ofs   = ofs;
        return a.raw;
    endfunction

    task automatic l1_transfer(input logic we, input logic [`L2_ADDR_W-1:0] adr,
                               input logic [`L2_WORD_W-1:0] data);
        @(posedge clk);
        l1_cyc   <= 1'b1;
        l1_stb   <= 1'b1;
        l1_we    <= we;
        l1_adr   <= adr;
        l1_wdata <= data;
        if (we)
            shadow[32'(adr)] = data;
        else
            exp_rdata <= expected_word(adr);
        @(posedge clk);
        while (!l1_ack)
            @(posedge clk);
        l1_cyc <= 1'b0;
        l1_stb <= 1'b0;
        l1_we  <= 1'b0;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    l2_cache_top i_l2_cache_top (
        .clk       (clk),
        .nrst      (nrst),
        .l1_cyc    (l1_cyc),
        .l1_stb    (l1_stb),
        .l1_we     (l1_we),
        .l1_adr    (l1_adr),
        .l1_wdata  (l1_wdata),
        .l1_rdata  (l1_rdata),
        .l1_ack    (l1_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack)
    );

    l2_checker i_l2_checker (
        .clk        (clk),
        .nrst       (nrst),
        .l1_cyc     (l1_cyc),
        .l1_stb     (l1_stb),
        .l1_we      (l1_we),
        .l1_adr     (l1_adr),
        .l1_wdata   (l1_wdata),
        .l1_rdata   (l1_rdata),
        .l1_ack     (l1_ack),
        .mem_cyc    (mem_cyc),
        .mem_stb    (mem_stb),
        .mem_we     (mem_we),
        .mem_adr    (mem_adr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack),
        .exp_rdata  (exp_rdata),
        .run_done   (run_done),
        .mismatches (mismatches),
        .failures   (failures),
        .xfers      (xfers)
    );

    // memory slave, 0 to 3 wait cycles per transfer
    always @(posedge clk)
    begin
        mem_ack <= 1'b0;
        if (mem_cyc && mem_stb && !mem_ack)
        begin
            if (mem_wait > 0)
                mem_wait = mem_wait - 1;
            else
            begin
                if (mem_we)
                    mem_lines[32'(mem_adr)] = mem_wdata;
                else
                    mem_rdata <= memory_line(mem_adr);
                mem_ack <= 1'b1;
                mem_wait = $unsigned($random(delay_seed)) % 4;
            end
        end
    end

    initial
    begin
        logic [`L2_TAG_W-1:0]   rnd_tag;
        logic [`L2_INDEX_W-1:0] rnd_idx;
        logic [`L2_OFS_W-1:0]   rnd_ofs;
        logic                   rnd_we;
        logic [`L2_WORD_W-1:0]  rnd_data;
        seed       = 45;
        delay_seed = 45;
        mem_wait   = 0;
        nrst       = 1'b0;
        l1_cyc     = 1'b0;
        l1_stb     = 1'b0;
        l1_we      = 1'b0;
        l1_adr     = '0;
        l1_wdata   = '0;
        mem_rdata  = '0;
        mem_ack    = 1'b0;
        exp_rdata  = '0;
        run_done   = 1'b0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;

        $display("read miss, then hit, then write hit");
        l1_transfer(1'b0, make_adr(18'h11, 8'h05, 2'd1), '0);
        l1_transfer(1'b0, make_adr(18'h11, 8'h05, 2'd2), '0);
        l1_transfer(1'b1, make_adr(18'h11, 8'h05, 2'd2), 32'hdead_beef);
        l1_transfer(1'b0, make_adr(18'h11, 8'h05, 2'd2), '0);
        l1_transfer(1'b0, make_adr(18'h11, 8'h05, 2'd1), '0);   // neighbours untouched
        l1_transfer(1'b0, make_adr(18'h11, 8'h05, 2'd3), '0);

        $display("lru eviction in set 0x10");
        l1_transfer(1'b1, make_adr(18'h100, 8'h10, 2'd0), 32'h0a0a_0001);  // A, way 0
        l1_transfer(1'b0, make_adr(18'h101, 8'h10, 2'd0), '0);             // B
        l1_transfer(1'b1, make_adr(18'h102, 8'h10, 2'd3), 32'h0c0c_0003);  // C
        l1_transfer(1'b0, make_adr(18'h103, 8'h10, 2'd0), '0);             // D, set full
        l1_transfer(1'b0, make_adr(18'h100, 8'h10, 2'd1), '0);
        l1_transfer(1'b0, make_adr(18'h102, 8'h10, 2'd1), '0);
        l1_transfer(1'b0, make_adr(18'h104, 8'h10, 2'd2), '0);     // B out, clean
        l1_transfer(1'b0, make_adr(18'h105, 8'h10, 2'd2), '0);     // D out, clean
        l1_transfer(1'b0, make_adr(18'h106, 8'h10, 2'd2), '0);     // A out, written back
        l1_transfer(1'b0, make_adr(18'h100, 8'h10, 2'd0), '0);     // C out, A from memory
        l1_transfer(1'b0, make_adr(18'h102, 8'h10, 2'd3), '0);

        $display("random traffic, %0d requests", N_RANDOM);
        for (int n = 0; n < N_RANDOM; n++)
        begin
            rnd_tag  = 18'h2000 + 18'($unsigned($random(seed)) % 6);
            rnd_idx  = 8'h20 + 8'($unsigned($random(seed)) % 4);
            rnd_ofs  = 2'($unsigned($random(seed)));
            rnd_we   = 1'($unsigned($random(seed)));
            rnd_data = $random(seed);
            l1_transfer(rnd_we, make_adr(rnd_tag, rnd_idx, rnd_ofs), rnd_data);
        end

        repeat (5) @(posedge clk);
        run_done <= 1'b1;
        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d other failures; %0d memory transfers",
                 mismatches, failures, xfers);
        if (mismatches == 0 && failures == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+source
source/l2_cache_pkg.sv
source/l2_lookup_if.sv
source/l2_lru_table.sv
source/l2_tag_store.sv
source/l2_data_array.sv
source/l2_controller.sv
source/l2_cache_top.sv
tb/l2_checker.sv
tb/tb_l2_cache.sv

//--- Makefile
TOP = tb_l2_cache

sim:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean
